// File: Bender.yml
package:
  name: cpu_axi_bridge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_axi_pkg.sv
      - axi_master_port.sv
      - pipeline_stall_ctrl.sv
      - cpu_axi_bridge.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_axi_mem_model.sv
      - tb_cpu_axi_bridge.sv

// File: axi_master_port.sv
`timescale 1ns/10ps
`include "cpu_axi_defines.svh"

module axi_master_port #(
  parameter int unsigned PORT_ID = 0
) (
  input  logic                  clk,
  input  logic                  rst,

  input  cpu_axi_pkg::mem_req_t req_i,
  input  logic                  issue_i,
  output cpu_axi_pkg::mem_rsp_t rsp_o,
  output logic                  done_o,

  output cpu_axi_pkg::axi_ar_t  ar_o,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,

  output cpu_axi_pkg::axi_aw_t  aw_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,

  output cpu_axi_pkg::axi_w_t   w_o,
  output logic                  w_valid_o,
  input  logic                  w_ready_i,

  input  cpu_axi_pkg::axi_r_t   r_i,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,

  input  cpu_axi_pkg::axi_b_t   b_i,
  input  logic                  b_valid_i,
  output logic                  b_ready_o
);

  import cpu_axi_pkg::*;

  port_state_e state_q, state_d;

  logic  is_write_q;
  logic  wr_req;
  logic  accept;
  logic  ar_valid_q, aw_valid_q, w_valid_q;
  logic  ar_left, aw_left, w_left;
  logic  r_beat, b_beat;

  addr_t addr_q;
  data_t wdata_q;
  strb_t strb_q;
  data_t rdata_q;

  assign wr_req = |req_i.write;
  assign accept = (state_q == IDLE) && issue_i;

  // Handshakes still outstanding after this edge
  assign ar_left = ar_valid_q && !ar_ready_i;
  assign aw_left = aw_valid_q && !aw_ready_i;
  assign w_left  = w_valid_q && !w_ready_i;

  assign r_beat = r_valid_i && r_ready_o;
  assign b_beat = b_valid_i && b_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (issue_i) state_d = ADDR;
      end
      ADDR: begin
        // AW and W may finish in either order
        if (!(ar_left || aw_left || w_left)) state_d = RESP;
      end
      RESP: begin
        if (r_beat || b_beat) state_d = DONE;
      end
      DONE: state_d = IDLE;  // Single cycle
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= IDLE;
      is_write_q <= 1'b0;
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        is_write_q <= wr_req;
        ar_valid_q <= !wr_req;
        aw_valid_q <= wr_req;
        w_valid_q  <= wr_req;
      end else begin
        ar_valid_q <= ar_left;  // Each valid drops on its own handshake
        aw_valid_q <= aw_left;
        w_valid_q  <= w_left;
      end
    end
  end

  // Request and read data registers
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= req_i.addr;
      wdata_q <= req_i.wdata;
      strb_q  <= req_i.write;
    end
    if (r_beat) rdata_q <= r_i.data;
  end

  assign ar_o.id    = axi_id_t'(PORT_ID);
  assign ar_o.addr  = addr_q;
  assign ar_o.len   = '0;  // One beat
  assign ar_o.size  = `CPU_AXI_SIZE_4B;
  assign ar_o.burst = `CPU_AXI_BURST_INCR;
  assign ar_valid_o = ar_valid_q;

  assign aw_o.id    = axi_id_t'(PORT_ID);
  assign aw_o.addr  = addr_q;
  assign aw_o.len   = '0;
  assign aw_o.size  = `CPU_AXI_SIZE_4B;
  assign aw_o.burst = `CPU_AXI_BURST_INCR;
  assign aw_valid_o = aw_valid_q;

  assign w_o.data  = wdata_q;
  assign w_o.strb  = strb_q;
  assign w_o.last  = 1'b1;
  assign w_valid_o = w_valid_q;

  // Responses taken whatever RRESP and BRESP say
  assign r_ready_o = (state_q == RESP) && !is_write_q;
  assign b_ready_o = (state_q == RESP) && is_write_q;

  assign done_o      = (state_q == DONE);
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.done  = done_o;

  ar_stable_a : assert property (@(posedge clk) disable iff (rst)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

  aw_stable_a : assert property (@(posedge clk) disable iff (rst)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o));

  w_stable_a : assert property (@(posedge clk) disable iff (rst)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o));

  // Nothing left in flight once done shows
  done_quiet_a : assert property (@(posedge clk) disable iff (rst)
    done_o |-> !(ar_valid_o || aw_valid_o || w_valid_o));

endmodule

// File: cpu_axi_bridge.sv
`timescale 1ns/10ps
`include "cpu_axi_defines.svh"

module cpu_axi_bridge (
  input  logic                                           clk,
  input  logic                                           rst,

  input  cpu_axi_pkg::mem_req_t [`CPU_AXI_NUM_PORTS-1:0] mem_req_i,
  output cpu_axi_pkg::mem_rsp_t [`CPU_AXI_NUM_PORTS-1:0] mem_rsp_o,
  output logic                                           stall_o,

  output cpu_axi_pkg::axi_ar_t  [`CPU_AXI_NUM_PORTS-1:0] ar_o,
  output logic [`CPU_AXI_NUM_PORTS-1:0]                  ar_valid_o,
  input  logic [`CPU_AXI_NUM_PORTS-1:0]                  ar_ready_i,

  output cpu_axi_pkg::axi_aw_t  [`CPU_AXI_NUM_PORTS-1:0] aw_o,
  output logic [`CPU_AXI_NUM_PORTS-1:0]                  aw_valid_o,
  input  logic [`CPU_AXI_NUM_PORTS-1:0]                  aw_ready_i,

  output cpu_axi_pkg::axi_w_t   [`CPU_AXI_NUM_PORTS-1:0] w_o,
  output logic [`CPU_AXI_NUM_PORTS-1:0]                  w_valid_o,
  input  logic [`CPU_AXI_NUM_PORTS-1:0]                  w_ready_i,

  input  cpu_axi_pkg::axi_r_t   [`CPU_AXI_NUM_PORTS-1:0] r_i,
  input  logic [`CPU_AXI_NUM_PORTS-1:0]                  r_valid_i,
  output logic [`CPU_AXI_NUM_PORTS-1:0]                  r_ready_o,

  input  cpu_axi_pkg::axi_b_t   [`CPU_AXI_NUM_PORTS-1:0] b_i,
  input  logic [`CPU_AXI_NUM_PORTS-1:0]                  b_valid_i,
  output logic [`CPU_AXI_NUM_PORTS-1:0]                  b_ready_o
);

  logic [`CPU_AXI_NUM_PORTS-1:0] issue;
  logic [`CPU_AXI_NUM_PORTS-1:0] done;

  pipeline_stall_ctrl i_stall_ctrl (
    .clk     (clk),
    .rst     (rst),
    .req_i   (mem_req_i),
    .done_i  (done),
    .issue_o (issue),
    .stall_o (stall_o)
  );

  // Port index doubles as AXI ID
  for (genvar p = 0; p < `CPU_AXI_NUM_PORTS; p++) begin : g_port
    axi_master_port #(
      .PORT_ID (p)
    ) i_port (
      .clk        (clk),
      .rst        (rst),
      .req_i      (mem_req_i[p]),
      .issue_i    (issue[p]),
      .rsp_o      (mem_rsp_o[p]),
      .done_o     (done[p]),
      .ar_o       (ar_o[p]),
      .ar_valid_o (ar_valid_o[p]),
      .ar_ready_i (ar_ready_i[p]),
      .aw_o       (aw_o[p]),
      .aw_valid_o (aw_valid_o[p]),
      .aw_ready_i (aw_ready_i[p]),
      .w_o        (w_o[p]),
      .w_valid_o  (w_valid_o[p]),
      .w_ready_i  (w_ready_i[p]),
      .r_i        (r_i[p]),
      .r_valid_i  (r_valid_i[p]),
      .r_ready_o  (r_ready_o[p]),
      .b_i        (b_i[p]),
      .b_valid_i  (b_valid_i[p]),
      .b_ready_o  (b_ready_o[p])
    );
  end

endmodule

// File: cpu_axi_defines.svh
`ifndef CPU_AXI_DEFINES_SVH
`define CPU_AXI_DEFINES_SVH

// Port 0 fetch, port 1 data
`define CPU_AXI_NUM_PORTS 2

`define CPU_AXI_ADDR_W 32
`define CPU_AXI_DATA_W 32
`define CPU_AXI_STRB_W (`CPU_AXI_DATA_W / 8)
`define CPU_AXI_ID_W 4

// AXI field widths and codes
`define CPU_AXI_LEN_W 8
`define CPU_AXI_SIZE_W 3
`define CPU_AXI_BURST_W 2
`define CPU_AXI_RESP_W 2

`define CPU_AXI_BURST_INCR 2'b01
`define CPU_AXI_SIZE_4B 3'b010

// Cycles to wait for a transaction before giving up
`define CPU_AXI_TIMEOUT 2000

`endif

// File: cpu_axi_pkg.sv
`include "cpu_axi_defines.svh"

package cpu_axi_pkg;

  typedef logic [`CPU_AXI_ADDR_W-1:0] addr_t;
  typedef logic [`CPU_AXI_DATA_W-1:0] data_t;
  typedef logic [`CPU_AXI_STRB_W-1:0] strb_t;
  typedef logic [`CPU_AXI_ID_W-1:0] axi_id_t;
  typedef logic [`CPU_AXI_LEN_W-1:0] axi_len_t;
  typedef logic [`CPU_AXI_SIZE_W-1:0] axi_size_t;
  typedef logic [`CPU_AXI_BURST_W-1:0] axi_burst_t;
  typedef logic [`CPU_AXI_RESP_W-1:0] axi_resp_t;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RESP,
    DONE
  } port_state_e;

  // Core side, held while stalled
  typedef struct packed {
    logic  read;
    strb_t write;  // Nonzero means a write
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    data_t rdata;
    logic  done;
  } mem_rsp_t;

  typedef struct packed {
    axi_id_t    id;
    addr_t      addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ar_t;

  typedef struct packed {
    axi_id_t    id;
    addr_t      addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    data_t     data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

endpackage

// File: list.f
+incdir+.
cpu_axi_pkg.sv
axi_master_port.sv
pipeline_stall_ctrl.sv
cpu_axi_bridge.sv
tb_axi_mem_model.sv
tb_cpu_axi_bridge.sv

// File: pipeline_stall_ctrl.sv
`timescale 1ns/10ps
`include "cpu_axi_defines.svh"

module pipeline_stall_ctrl (
  input  logic                                           clk,
  input  logic                                           rst,
  input  cpu_axi_pkg::mem_req_t [`CPU_AXI_NUM_PORTS-1:0] req_i,
  input  logic [`CPU_AXI_NUM_PORTS-1:0]                  done_i,
  output logic [`CPU_AXI_NUM_PORTS-1:0]                  issue_o,
  output logic                                           stall_o
);

  logic [`CPU_AXI_NUM_PORTS-1:0] req_present;
  logic [`CPU_AXI_NUM_PORTS-1:0] served_q;
  logic [`CPU_AXI_NUM_PORTS-1:0] pending;

  always_comb begin
    for (int p = 0; p < `CPU_AXI_NUM_PORTS; p++) begin
      req_present[p] = req_i[p].read || (|req_i[p].write);
    end
  end

  // Finishing this cycle counts as no longer pending
  assign pending = req_present & ~served_q & ~done_i;
  assign stall_o = |pending;

  assign issue_o = req_present & ~served_q;  // Served ports wait for the stall to end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      served_q <= '0;
    end else if (!stall_o) begin
      served_q <= '0;  // Core moves on at this edge
    end else begin
      served_q <= served_q | done_i;
    end
  end

  for (genvar p = 0; p < `CPU_AXI_NUM_PORTS; p++) begin : g_chk
    // A served port still holds its request and is not issued again
    served_held_a : assert property (@(posedge clk) disable iff (rst)
      served_q[p] |-> req_present[p] && !issue_o[p]);
  end

endmodule

// File: tb_axi_mem_model.sv
`timescale 1ns/10ps
`include "cpu_axi_defines.svh"

module tb_axi_mem_model #(
  parameter int unsigned PORT_ID = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_axi_pkg::axi_ar_t ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  input  cpu_axi_pkg::axi_aw_t aw_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  cpu_axi_pkg::axi_w_t  w_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output cpu_axi_pkg::axi_r_t  r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  output cpu_axi_pkg::axi_b_t  b_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  output int                   rd_cnt_o,
  output int                   aw_cnt_o,
  output int                   w_cnt_o,
  output int                   err_cnt_o
);

  import cpu_axi_pkg::*;

  addr_t   rd_q[$];
  addr_t   wa_q[$];
  axi_w_t  wd_q[$];
  axi_ar_t ar_seen;
  axi_aw_t aw_seen;
  axi_w_t  w_seen;
  addr_t   r_addr, b_addr;
  axi_w_t  b_data;
  int      r_wait, b_wait;

  // One 4-byte INCR beat tagged with this port's ID
  function automatic bit single_beat_ok(axi_id_t id, axi_len_t len, axi_size_t size,
                                        axi_burst_t burst);
    return (id === axi_id_t'(PORT_ID)) && (len === 8'd0) && (size === 3'b010)
           && (burst === 2'b01);
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    r_valid_o  = 1'b0;
    b_valid_o  = 1'b0;
    r_o        = '0;
    b_o        = '0;
    rd_cnt_o   = 0;
    aw_cnt_o   = 0;
    w_cnt_o    = 0;
    err_cnt_o  = 0;
  end

  always begin  // AR
    @(posedge clk);
    #1;
    if (!rst && ar_valid_i) begin
      ar_seen = ar_i;
      repeat ($urandom_range(0, 5)) begin
        @(posedge clk);
        #1;
      end
      if (!ar_valid_i || ar_i !== ar_seen) begin
        $display("Memory model %0d: read address dropped or changed before ready", PORT_ID);
        err_cnt_o++;
      end
      if (!single_beat_ok(ar_seen.id, ar_seen.len, ar_seen.size, ar_seen.burst)) begin
        $display("Memory model %0d: read address is not one 4-byte beat with this ID",
                 PORT_ID);
        err_cnt_o++;
      end
      ar_ready_o = 1'b1;
      @(posedge clk);
      #1;
      ar_ready_o = 1'b0;
      rd_q.push_back(ar_seen.addr);
      rd_cnt_o++;
    end
  end

  always begin  // AW
    @(posedge clk);
    #1;
    if (!rst && aw_valid_i) begin
      aw_seen = aw_i;
      repeat ($urandom_range(0, 5)) begin
        @(posedge clk);
        #1;
      end
      if (!aw_valid_i || aw_i !== aw_seen) begin
        $display("Memory model %0d: write address dropped or changed before ready", PORT_ID);
        err_cnt_o++;
      end
      if (!single_beat_ok(aw_seen.id, aw_seen.len, aw_seen.size, aw_seen.burst)) begin
        $display("Memory model %0d: write address is not one 4-byte beat with this ID",
                 PORT_ID);
        err_cnt_o++;
      end
      aw_ready_o = 1'b1;
      @(posedge clk);
      #1;
      aw_ready_o = 1'b0;
      wa_q.push_back(aw_seen.addr);
      aw_cnt_o++;
    end
  end

  always begin  // W
    @(posedge clk);
    #1;
    if (!rst && w_valid_i) begin
      w_seen = w_i;
      repeat ($urandom_range(0, 5)) begin
        @(posedge clk);
        #1;
      end
      if (!w_valid_i || w_i !== w_seen) begin
        $display("Memory model %0d: write data dropped or changed before ready", PORT_ID);
        err_cnt_o++;
      end
      if (w_seen.last !== 1'b1) begin
        $display("Memory model %0d: single write beat is not marked last", PORT_ID);
        err_cnt_o++;
      end
      w_ready_o = 1'b1;
      @(posedge clk);
      #1;
      w_ready_o = 1'b0;
      wd_q.push_back(w_seen);
      w_cnt_o++;
    end
  end

  always begin  // R
    @(posedge clk);
    #1;
    if (rd_q.size() > 0) begin
      r_addr = rd_q.pop_front();
      repeat ($urandom_range(0, 5)) begin
        @(posedge clk);
        #1;
      end
      r_o.id    = axi_id_t'(PORT_ID);
      r_o.data  = tb_cpu_axi_bridge.mem_read(r_addr);
      r_o.resp  = '0;
      r_o.last  = 1'b1;
      r_valid_o = 1'b1;
      r_wait = 0;
      while (!r_ready_i && r_wait < `CPU_AXI_TIMEOUT) begin
        @(posedge clk);
        #1;
        r_wait++;
      end
      if (r_wait >= `CPU_AXI_TIMEOUT) begin
        $display("Memory model %0d: read data never accepted", PORT_ID);
        err_cnt_o++;
      end
      @(posedge clk);
      #1;
      r_valid_o = 1'b0;
    end
  end

  always begin  // B, once both address and data are in
    @(posedge clk);
    #1;
    if (wa_q.size() > 0 && wd_q.size() > 0) begin
      b_addr = wa_q.pop_front();
      b_data = wd_q.pop_front();
      tb_cpu_axi_bridge.mem_write(b_addr, b_data.data, b_data.strb);
      repeat ($urandom_range(0, 5)) begin
        @(posedge clk);
        #1;
      end
      b_o.id    = axi_id_t'(PORT_ID);
      b_o.resp  = '0;
      b_valid_o = 1'b1;
      b_wait = 0;
      while (!b_ready_i && b_wait < `CPU_AXI_TIMEOUT) begin
        @(posedge clk);
        #1;
        b_wait++;
      end
      if (b_wait >= `CPU_AXI_TIMEOUT) begin
        $display("Memory model %0d: write response never accepted", PORT_ID);
        err_cnt_o++;
      end
      @(posedge clk);
      #1;
      b_valid_o = 1'b0;
    end
  end

endmodule

// File: tb_cpu_axi_bridge.sv
`timescale 1ns/10ps
`include "cpu_axi_defines.svh"

module tb_cpu_axi_bridge;

  import cpu_axi_pkg::*;

  localparam int NP = `CPU_AXI_NUM_PORTS;
  localparam int SEED = 32'h2e5d;
  localparam int RESET_CYCLES = 10;

  logic clk, rst, stall;
  mem_req_t [NP-1:0] mem_req;
  mem_rsp_t [NP-1:0] mem_rsp;
  axi_ar_t  [NP-1:0] ar;
  axi_aw_t  [NP-1:0] aw;
  axi_w_t   [NP-1:0] w;
  wire axi_r_t [NP-1:0] r;
  wire axi_b_t [NP-1:0] b;
  logic [NP-1:0] ar_valid, aw_valid, w_valid, r_ready, b_ready;
  wire  [NP-1:0] ar_ready, aw_ready, w_ready, r_valid, b_valid;

  int rd_cnt[NP], aw_cnt[NP], w_cnt[NP], model_err[NP], done_cnt[NP];
  data_t mem[addr_t];      // Shared by both memory models
  data_t ref_mem[addr_t];  // Expected contents
  logic [32:0] exp_q[NP][$];  // Bit 32 marks a read
  logic [32:0] cmp_entry;
  int errors, test_errors, tests_run, tests_failed, err_base;
  string test_name;

  cpu_axi_bridge i_cpu_axi_bridge (
    .clk (clk), .rst (rst), .mem_req_i (mem_req), .mem_rsp_o (mem_rsp), .stall_o (stall),
    .ar_o (ar), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
    .aw_o (aw), .aw_valid_o (aw_valid), .aw_ready_i (aw_ready),
    .w_o (w), .w_valid_o (w_valid), .w_ready_i (w_ready),
    .r_i (r), .r_valid_i (r_valid), .r_ready_o (r_ready),
    .b_i (b), .b_valid_i (b_valid), .b_ready_o (b_ready)
  );

  for (genvar p = 0; p < NP; p++) begin : g_mem
    tb_axi_mem_model #(.PORT_ID (p)) i_mem (
      .clk (clk), .rst (rst),
      .ar_i (ar[p]), .ar_valid_i (ar_valid[p]), .ar_ready_o (ar_ready[p]),
      .aw_i (aw[p]), .aw_valid_i (aw_valid[p]), .aw_ready_o (aw_ready[p]),
      .w_i (w[p]), .w_valid_i (w_valid[p]), .w_ready_o (w_ready[p]),
      .r_o (r[p]), .r_valid_o (r_valid[p]), .r_ready_i (r_ready[p]),
      .b_o (b[p]), .b_valid_o (b_valid[p]), .b_ready_i (b_ready[p]),
      .rd_cnt_o (rd_cnt[p]), .aw_cnt_o (aw_cnt[p]), .w_cnt_o (w_cnt[p]),
      .err_cnt_o (model_err[p])
    );
  end

  function automatic data_t preset_word(addr_t a);
    return {a[15:0], a[31:16]} ^ 32'h3c96_a55a;
  endfunction

  function automatic data_t mem_read(addr_t a);
    return mem.exists(a) ? mem[a] : preset_word(a);
  endfunction

  function automatic void mem_write(addr_t a, data_t d, strb_t s);
    data_t word;
    word = mem_read(a);
    for (int i = 0; i < `CPU_AXI_STRB_W; i++) begin
      if (s[i]) word[i*8 +: 8] = d[i*8 +: 8];
    end
    mem[a] = word;
  endfunction

  // Reference model of a strobed write
  function automatic data_t ref_merge(data_t old, data_t d, strb_t s);
    data_t mask;
    for (int i = 0; i < `CPU_AXI_STRB_W; i++) mask[i*8 +: 8] = {8{s[i]}};
    return (old & ~mask) | (d & mask);
  endfunction

  function automatic data_t ref_word(addr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : preset_word(a);
  endfunction

  function automatic mem_req_t make_req(logic rd, strb_t st, addr_t a, data_t d);
    mem_req_t q;
    q.read  = rd;
    q.write = st;
    q.addr  = a;
    q.wdata = d;
    return q;
  endfunction

  task automatic check_value(string what, data_t exp, data_t act);
    assert (exp === act) else begin
      $display("CHECK FAILED %s (%s): expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic abort_run(string what);
    $display("Timeout while %s in test %s", what, test_name);
    $display("STATUS: FAIL");
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Compare process, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < NP; p++) begin
        if (mem_rsp[p].done) begin
          done_cnt[p]++;
          if (exp_q[p].size() == 0) begin
            $display("Port %0d finished a transaction that was never requested", p);
            test_errors++;
          end else begin
            cmp_entry = exp_q[p].pop_front();
            if (cmp_entry[32]) check_value($sformatf("port %0d read", p), cmp_entry[31:0],
                                           mem_rsp[p].rdata);
          end
        end
      end
    end
  end

  task automatic run_request(mem_req_t r0, mem_req_t r1);
    mem_req_t rq[NP];
    int base_done[NP], base_rd[NP], base_aw[NP], base_w[NP];
    int t;
    rq[0] = r0;
    rq[1] = r1;
    for (int p = 0; p < NP; p++) begin
      base_done[p] = done_cnt[p];
      base_rd[p]   = rd_cnt[p];
      base_aw[p]   = aw_cnt[p];
      base_w[p]    = w_cnt[p];
      if (rq[p].read) begin
        exp_q[p].push_back({1'b1, ref_word(rq[p].addr)});
      end else if (|rq[p].write) begin
        exp_q[p].push_back({1'b0, 32'h0});
        ref_mem[rq[p].addr] = ref_merge(ref_word(rq[p].addr), rq[p].wdata, rq[p].write);
      end
    end
    mem_req[0] = r0;
    mem_req[1] = r1;
    #1;  // Stall is combinational from the request
    check_value("stall on new request", 1, stall);
    t = 0;
    while (stall && t < `CPU_AXI_TIMEOUT) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (t >= `CPU_AXI_TIMEOUT) abort_run("waiting for the stall to drop");
    @(posedge clk);  // Core moves on at this edge
    #1;
    mem_req = '0;
    for (int p = 0; p < NP; p++) begin
      check_value($sformatf("port %0d done pulses", p), (rq[p].read || |rq[p].write) ? 1 : 0,
                  done_cnt[p] - base_done[p]);
      check_value($sformatf("port %0d reads", p), rq[p].read, rd_cnt[p] - base_rd[p]);
      check_value($sformatf("port %0d write addresses", p), |rq[p].write, aw_cnt[p] - base_aw[p]);
      check_value($sformatf("port %0d write beats", p), |rq[p].write, w_cnt[p] - base_w[p]);
    end
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_errors = 0;
    err_base = model_err[0] + model_err[1];
  endtask

  task automatic end_test();
    test_errors += model_err[0] + model_err[1] - err_base;
    tests_run++;
    errors += test_errors;
    if (test_errors != 0) tests_failed++;
    $display("Test %s: %s (%0d errors)", test_name, test_errors ? "failed" : "ok", test_errors);
  endtask

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    mem_req = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int p = 0; p < NP; p++) done_cnt[p] = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test("reset");
    check_value("outputs after reset", 0, {ar_valid, aw_valid, w_valid, r_ready, b_ready,
                mem_rsp[0].done, mem_rsp[1].done, stall});
    end_test();

    start_test("fetch_reads");
    for (int i = 0; i < 8; i++) run_request(make_req(1'b1, '0, 32'h1000 + 4 * i, '0), '0);
    end_test();

    start_test("strobed_writes");
    for (int i = 0; i < 6; i++) begin
      run_request('0, make_req(1'b0, strb_t'($urandom_range(1, 15)), 32'h8000 + 4 * i,
                               $urandom()));
    end
    for (int i = 0; i < 6; i++) run_request('0, make_req(1'b1, '0, 32'h8000 + 4 * i, '0));
    end_test();

    start_test("concurrent");
    for (int i = 0; i < 8; i++) begin
      run_request(make_req(1'b1, '0, 32'h2000 + 4 * i, '0),
                  (i % 2) ? make_req(1'b1, '0, 32'h8000 + 4 * (i % 6), '0)
                          : make_req(1'b0, strb_t'($urandom_range(1, 15)),
                                     32'h8000 + 4 * (i % 6), $urandom()));
    end
    end_test();

    start_test("back_pressure");
    for (int i = 0; i < 16; i++) begin
      run_request($urandom_range(0, 1) ? make_req(1'b1, '0, 32'h3000 + 4 * i, '0) : '0,
                  $urandom_range(0, 1) ? make_req(1'b1, '0, 32'h8040 + 4 * (i % 4), '0)
                                       : make_req(1'b0, strb_t'($urandom_range(1, 15)),
                                                  32'h8040 + 4 * (i % 4), $urandom()));
    end
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
